/* hdl/dsc_queue_manager.sv */
`timescale 1ns/1ps
`default_nettype none

module dsc_queue_manager (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,

    input  var pcie_rx_pkg::pkt_qid_t  mid_pkt_qid,
    input  var pcie_rx_pkg::rb_ptr_t   mid_pkt_ptr,
    input  var pcie_rx_pkg::dsc_qid_t  mid_dsc_qid,
    input  var pcie_rx_pkg::flit_cnt_t mid_size,
    input  logic                       mid_valid,
    output logic                       mid_ready,

    output pcie_rx_pkg::pkt_qid_t      out_pkt_qid,
    output pcie_rx_pkg::rb_ptr_t       out_pkt_ptr,
    output pcie_rx_pkg::dsc_qid_t      out_dsc_qid,
    output pcie_rx_pkg::rb_ptr_t       out_dsc_ptr,
    output pcie_rx_pkg::flit_cnt_t     out_size,
    output logic                       out_valid,
    input  logic                       out_ready,

    input  var pcie_rx_pkg::rb_size_t  dsc_rb_size,
    input  logic                       dsc_head_wr,
    input  var pcie_rx_pkg::dsc_qid_t  dsc_head_idx,
    input  var pcie_rx_pkg::rb_ptr_t   dsc_head_data,
    input  var pcie_rx_pkg::dsc_qid_t  dsc_rd_idx,
    output pcie_rx_pkg::rb_ptr_t       dsc_rd_tail,
    output pcie_rx_pkg::rb_ptr_t       dsc_rd_head,
    output pcie_rx_pkg::reg_t          dsc_full_cnt
);

import pcie_rx_pkg::*;

rb_ptr_t  tails [NB_DSC_QUEUES];
rb_ptr_t  heads [NB_DSC_QUEUES];

logic     mid_fire;
logic     fits;
rb_ptr_t  cur_tail;
rb_size_t free_space;

assign mid_ready  = !out_valid || out_ready;
assign mid_fire   = mid_valid && mid_ready;
assign cur_tail   = tails[mid_dsc_qid];
assign free_space = rb_free(heads[mid_dsc_qid], cur_tail, dsc_rb_size);
// Every packet takes exactly one descriptor slot.
assign fits       = free_space != '0;

assign dsc_rd_tail = tails[dsc_rd_idx];
assign dsc_rd_head = heads[dsc_rd_idx];

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        out_valid    <= 1'b0;
        dsc_full_cnt <= '0;
        for (int q = 0; q < NB_DSC_QUEUES; q++) begin
            tails[q] <= '0;
            heads[q] <= '0;
        end
    end else begin
        if (mid_ready) begin
            out_valid <= mid_fire && fits;
        end
        if (mid_fire) begin
            if (fits) begin
                tails[mid_dsc_qid] <= rb_advance(cur_tail, rb_size_t'(1), dsc_rb_size);
            end else begin
                dsc_full_cnt <= dsc_full_cnt + 1'b1;
            end
        end
        if (dsc_head_wr) begin
            heads[dsc_head_idx] <= dsc_head_data;
        end
    end
end

always_ff @(posedge pcie_clk) begin
    if (mid_fire && fits) begin
        out_pkt_qid <= mid_pkt_qid;
        out_pkt_ptr <= mid_pkt_ptr;
        out_dsc_qid <= mid_dsc_qid;
        out_dsc_ptr <= cur_tail;
        out_size    <= mid_size;
    end
end

a_out_stable: assert property (
    @(posedge pcie_clk) disable iff (!pcie_reset_n)
    (out_valid && !out_ready) |=>
        (out_valid && $stable({out_pkt_qid, out_pkt_ptr, out_dsc_qid, out_dsc_ptr, out_size}))
) else $error("Descriptor output changed while stalled");

endmodule

`default_nettype wire

/* hdl/mmio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_regs (
    input  logic                        pcie_clk,
    input  logic                        pcie_reset_n,

    input  var pcie_rx_pkg::mmio_addr_t mmio_address,
    input  logic                        mmio_write,
    input  var pcie_rx_pkg::reg_t       mmio_writedata,
    input  logic                        mmio_read,
    output pcie_rx_pkg::reg_t           mmio_readdata,
    output logic                        mmio_readdata_valid,

    output logic                        rx_disable,
    output pcie_rx_pkg::rb_size_t       pkt_rb_size,
    output pcie_rx_pkg::rb_size_t       dsc_rb_size,

    output logic                        pkt_head_wr,
    output logic                        dsc_head_wr,
    output pcie_rx_pkg::pkt_qid_t       pkt_head_idx,
    output pcie_rx_pkg::dsc_qid_t       dsc_head_idx,
    output pcie_rx_pkg::rb_ptr_t        pkt_head_data,
    output pcie_rx_pkg::rb_ptr_t        dsc_head_data,

    output pcie_rx_pkg::pkt_qid_t       pkt_rd_idx,
    output pcie_rx_pkg::dsc_qid_t       dsc_rd_idx,
    input  var pcie_rx_pkg::rb_ptr_t    pkt_rd_tail,
    input  var pcie_rx_pkg::rb_ptr_t    pkt_rd_head,
    input  var pcie_rx_pkg::rb_ptr_t    dsc_rd_tail,
    input  var pcie_rx_pkg::rb_ptr_t    dsc_rd_head,
    input  var pcie_rx_pkg::reg_t       pkt_full_cnt,
    input  var pcie_rx_pkg::reg_t       dsc_full_cnt
);

import pcie_rx_pkg::*;

mmio_addr_t pkt_off;
mmio_addr_t dsc_off;
logic       pkt_hit;
logic       dsc_hit;
reg_t       head_upd_cnt;
reg_t       rd_data;

// Offsets wrap for addresses below a base, so one compare per region is enough.
assign pkt_off = mmio_address - PKT_Q_BASE;
assign dsc_off = mmio_address - DSC_Q_BASE;
assign pkt_hit = pkt_off < mmio_addr_t'(2 * NB_PKT_QUEUES);
assign dsc_hit = dsc_off < mmio_addr_t'(2 * NB_DSC_QUEUES);

// Bit 0 of the offset picks head over tail, the bits above it pick the queue.
assign pkt_rd_idx   = pkt_off[1 +: $bits(pkt_qid_t)];
assign dsc_rd_idx   = dsc_off[1 +: $bits(dsc_qid_t)];
assign pkt_head_idx = pkt_off[1 +: $bits(pkt_qid_t)];
assign dsc_head_idx = dsc_off[1 +: $bits(dsc_qid_t)];

assign pkt_head_wr   = mmio_write && pkt_hit && pkt_off[0];
assign dsc_head_wr   = mmio_write && dsc_hit && dsc_off[0];
assign pkt_head_data = rb_ptr_t'(mmio_writedata);
assign dsc_head_data = rb_ptr_t'(mmio_writedata);

always_comb begin
    rd_data = '0;
    if (pkt_hit) begin
        rd_data = pkt_off[0] ? reg_t'(pkt_rd_head) : reg_t'(pkt_rd_tail);
    end else if (dsc_hit) begin
        rd_data = dsc_off[0] ? reg_t'(dsc_rd_head) : reg_t'(dsc_rd_tail);
    end else begin
        case (mmio_address)
            REG_CTRL:         rd_data = reg_t'(rx_disable);
            REG_PKT_RB_SIZE:  rd_data = reg_t'(pkt_rb_size);
            REG_DSC_RB_SIZE:  rd_data = reg_t'(dsc_rb_size);
            REG_PKT_FULL_CNT: rd_data = pkt_full_cnt;
            REG_DSC_FULL_CNT: rd_data = dsc_full_cnt;
            REG_HEAD_UPD_CNT: rd_data = head_upd_cnt;
            default:          rd_data = '0;
        endcase
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        rx_disable          <= 1'b0;
        pkt_rb_size         <= PKT_RB_SIZE_RESET;
        dsc_rb_size         <= DSC_RB_SIZE_RESET;
        head_upd_cnt        <= '0;
        mmio_readdata_valid <= 1'b0;
    end else begin
        mmio_readdata_valid <= mmio_read;
        if (mmio_write) begin
            case (mmio_address)
                REG_CTRL:        rx_disable <= mmio_writedata[0];
                REG_PKT_RB_SIZE: pkt_rb_size <= rb_size_t'(mmio_writedata);
                REG_DSC_RB_SIZE: dsc_rb_size <= rb_size_t'(mmio_writedata);
                default:         ;
            endcase
        end
        // Counts head writes to both packet and descriptor rings.
        if (pkt_head_wr || dsc_head_wr) begin
            head_upd_cnt <= head_upd_cnt + 1'b1;
        end
    end
end

always_ff @(posedge pcie_clk) begin
    if (mmio_read) begin
        mmio_readdata <= rd_data;
    end
end

a_no_read_write: assert property (
    @(posedge pcie_clk) disable iff (!pcie_reset_n)
    !(mmio_read && mmio_write)
) else $error("MMIO read and write issued in the same cycle");

endmodule

`default_nettype wire

/* hdl/pcie_rx_pkg.sv */
`default_nettype none

package pcie_rx_pkg;

localparam int NB_PKT_QUEUES = 8;
localparam int NB_DSC_QUEUES = 4;
localparam int RB_AWIDTH     = 10;
localparam int REG_WIDTH     = 32;
localparam int MMIO_AWIDTH   = 12;

typedef logic [$clog2(NB_PKT_QUEUES)-1:0] pkt_qid_t;
typedef logic [$clog2(NB_DSC_QUEUES)-1:0] dsc_qid_t;
typedef logic [RB_AWIDTH-1:0]             rb_ptr_t;
// One bit wider than a pointer so that a full 1024-entry ring can be described.
typedef logic [RB_AWIDTH:0]               rb_size_t;
typedef logic [5:0]                       flit_cnt_t;
typedef logic [REG_WIDTH-1:0]             reg_t;
typedef logic [MMIO_AWIDTH-1:0]           mmio_addr_t;

localparam rb_size_t PKT_RB_SIZE_RESET = rb_size_t'(256);
localparam rb_size_t DSC_RB_SIZE_RESET = rb_size_t'(16);

// Register map, in 32-bit words.
localparam mmio_addr_t REG_CTRL         = mmio_addr_t'(0);
localparam mmio_addr_t REG_PKT_RB_SIZE  = mmio_addr_t'(1);
localparam mmio_addr_t REG_DSC_RB_SIZE  = mmio_addr_t'(2);
localparam mmio_addr_t REG_PKT_FULL_CNT = mmio_addr_t'(3);
localparam mmio_addr_t REG_DSC_FULL_CNT = mmio_addr_t'(4);
localparam mmio_addr_t REG_HEAD_UPD_CNT = mmio_addr_t'(5);
// Queue q owns base+2q (tail) and base+2q+1 (head) in each region.
localparam mmio_addr_t PKT_Q_BASE       = mmio_addr_t'(256);
localparam mmio_addr_t DSC_Q_BASE       = mmio_addr_t'(512);

// Free entries in a ring. One slot always stays empty to tell full from empty.
function automatic rb_size_t rb_free(rb_ptr_t head, rb_ptr_t tail, rb_size_t size);
    rb_size_t free_space;
    if (head > tail) begin
        free_space = rb_size_t'(head) - rb_size_t'(tail) - rb_size_t'(1);
    end else begin
        free_space = size + rb_size_t'(head) - rb_size_t'(tail) - rb_size_t'(1);
    end
    return free_space;
endfunction

function automatic rb_ptr_t rb_advance(rb_ptr_t tail, rb_size_t demand, rb_size_t size);
    rb_size_t next_tail;
    next_tail = rb_size_t'(tail) + demand;
    if (next_tail >= size) begin
        next_tail = next_tail - size;
    end
    return rb_ptr_t'(next_tail);
endfunction

endpackage

`default_nettype wire

/* hdl/pcie_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pcie_rx_top (
    input  logic                        pcie_clk,
    input  logic                        pcie_reset_n,

    // Metadata stream from the packet buffer side.
    input  var pcie_rx_pkg::pkt_qid_t   in_pkt_qid,
    input  var pcie_rx_pkg::dsc_qid_t   in_dsc_qid,
    input  var pcie_rx_pkg::flit_cnt_t  in_size,
    input  logic                        in_valid,
    output logic                        in_ready,

    // Descriptor stream with both ring positions.
    output pcie_rx_pkg::pkt_qid_t       out_pkt_qid,
    output pcie_rx_pkg::rb_ptr_t        out_pkt_ptr,
    output pcie_rx_pkg::dsc_qid_t       out_dsc_qid,
    output pcie_rx_pkg::rb_ptr_t        out_dsc_ptr,
    output pcie_rx_pkg::flit_cnt_t      out_size,
    output logic                        out_valid,
    input  logic                        out_ready,

    input  var pcie_rx_pkg::mmio_addr_t mmio_address,
    input  logic                        mmio_write,
    input  var pcie_rx_pkg::reg_t       mmio_writedata,
    input  logic                        mmio_read,
    output pcie_rx_pkg::reg_t           mmio_readdata,
    output logic                        mmio_readdata_valid
);

import pcie_rx_pkg::*;

pkt_qid_t  mid_pkt_qid;
rb_ptr_t   mid_pkt_ptr;
dsc_qid_t  mid_dsc_qid;
flit_cnt_t mid_size;
logic      mid_valid;
logic      mid_ready;

logic      rx_disable;
rb_size_t  pkt_rb_size;
rb_size_t  dsc_rb_size;

logic      pkt_head_wr;
pkt_qid_t  pkt_head_idx;
rb_ptr_t   pkt_head_data;
logic      dsc_head_wr;
dsc_qid_t  dsc_head_idx;
rb_ptr_t   dsc_head_data;

pkt_qid_t  pkt_rd_idx;
rb_ptr_t   pkt_rd_tail;
rb_ptr_t   pkt_rd_head;
reg_t      pkt_full_cnt;
dsc_qid_t  dsc_rd_idx;
rb_ptr_t   dsc_rd_tail;
rb_ptr_t   dsc_rd_head;
reg_t      dsc_full_cnt;

mmio_regs mmio_regs_inst (
    .pcie_clk            (pcie_clk),
    .pcie_reset_n        (pcie_reset_n),
    .mmio_address        (mmio_address),
    .mmio_write          (mmio_write),
    .mmio_writedata      (mmio_writedata),
    .mmio_read           (mmio_read),
    .mmio_readdata       (mmio_readdata),
    .mmio_readdata_valid (mmio_readdata_valid),
    .rx_disable          (rx_disable),
    .pkt_rb_size         (pkt_rb_size),
    .dsc_rb_size         (dsc_rb_size),
    .pkt_head_wr         (pkt_head_wr),
    .dsc_head_wr         (dsc_head_wr),
    .pkt_head_idx        (pkt_head_idx),
    .dsc_head_idx        (dsc_head_idx),
    .pkt_head_data       (pkt_head_data),
    .dsc_head_data       (dsc_head_data),
    .pkt_rd_idx          (pkt_rd_idx),
    .dsc_rd_idx          (dsc_rd_idx),
    .pkt_rd_tail         (pkt_rd_tail),
    .pkt_rd_head         (pkt_rd_head),
    .dsc_rd_tail         (dsc_rd_tail),
    .dsc_rd_head         (dsc_rd_head),
    .pkt_full_cnt        (pkt_full_cnt),
    .dsc_full_cnt        (dsc_full_cnt)
);

pkt_queue_manager pkt_queue_manager_inst (
    .pcie_clk      (pcie_clk),
    .pcie_reset_n  (pcie_reset_n),
    .in_pkt_qid    (in_pkt_qid),
    .in_dsc_qid    (in_dsc_qid),
    .in_size       (in_size),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .mid_pkt_qid   (mid_pkt_qid),
    .mid_pkt_ptr   (mid_pkt_ptr),
    .mid_dsc_qid   (mid_dsc_qid),
    .mid_size      (mid_size),
    .mid_valid     (mid_valid),
    .mid_ready     (mid_ready),
    .rx_disable    (rx_disable),
    .pkt_rb_size   (pkt_rb_size),
    .pkt_head_wr   (pkt_head_wr),
    .pkt_head_idx  (pkt_head_idx),
    .pkt_head_data (pkt_head_data),
    .pkt_rd_idx    (pkt_rd_idx),
    .pkt_rd_tail   (pkt_rd_tail),
    .pkt_rd_head   (pkt_rd_head),
    .pkt_full_cnt  (pkt_full_cnt)
);

dsc_queue_manager dsc_queue_manager_inst (
    .pcie_clk      (pcie_clk),
    .pcie_reset_n  (pcie_reset_n),
    .mid_pkt_qid   (mid_pkt_qid),
    .mid_pkt_ptr   (mid_pkt_ptr),
    .mid_dsc_qid   (mid_dsc_qid),
    .mid_size      (mid_size),
    .mid_valid     (mid_valid),
    .mid_ready     (mid_ready),
    .out_pkt_qid   (out_pkt_qid),
    .out_pkt_ptr   (out_pkt_ptr),
    .out_dsc_qid   (out_dsc_qid),
    .out_dsc_ptr   (out_dsc_ptr),
    .out_size      (out_size),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .dsc_rb_size   (dsc_rb_size),
    .dsc_head_wr   (dsc_head_wr),
    .dsc_head_idx  (dsc_head_idx),
    .dsc_head_data (dsc_head_data),
    .dsc_rd_idx    (dsc_rd_idx),
    .dsc_rd_tail   (dsc_rd_tail),
    .dsc_rd_head   (dsc_rd_head),
    .dsc_full_cnt  (dsc_full_cnt)
);

endmodule

`default_nettype wire

/* hdl/pkt_queue_manager.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_queue_manager (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,

    input  var pcie_rx_pkg::pkt_qid_t  in_pkt_qid,
    input  var pcie_rx_pkg::dsc_qid_t  in_dsc_qid,
    input  var pcie_rx_pkg::flit_cnt_t in_size,
    input  logic                       in_valid,
    output logic                       in_ready,

    output pcie_rx_pkg::pkt_qid_t      mid_pkt_qid,
    output pcie_rx_pkg::rb_ptr_t       mid_pkt_ptr,
    output pcie_rx_pkg::dsc_qid_t      mid_dsc_qid,
    output pcie_rx_pkg::flit_cnt_t     mid_size,
    output logic                       mid_valid,
    input  logic                       mid_ready,

    input  logic                       rx_disable,
    input  var pcie_rx_pkg::rb_size_t  pkt_rb_size,
    input  logic                       pkt_head_wr,
    input  var pcie_rx_pkg::pkt_qid_t  pkt_head_idx,
    input  var pcie_rx_pkg::rb_ptr_t   pkt_head_data,
    input  var pcie_rx_pkg::pkt_qid_t  pkt_rd_idx,
    output pcie_rx_pkg::rb_ptr_t       pkt_rd_tail,
    output pcie_rx_pkg::rb_ptr_t       pkt_rd_head,
    output pcie_rx_pkg::reg_t          pkt_full_cnt
);

import pcie_rx_pkg::*;

rb_ptr_t  tails [NB_PKT_QUEUES];
rb_ptr_t  heads [NB_PKT_QUEUES];

logic     running;
logic     in_fire;
logic     fits;
rb_ptr_t  cur_tail;
rb_size_t free_space;

// Stays low through reset and rises on the first edge after it.
assign in_ready   = running && !rx_disable && (!mid_valid || mid_ready);
assign in_fire    = in_valid && in_ready;
assign cur_tail   = tails[in_pkt_qid];
assign free_space = rb_free(heads[in_pkt_qid], cur_tail, pkt_rb_size);
assign fits       = rb_size_t'(in_size) <= free_space;

assign pkt_rd_tail = tails[pkt_rd_idx];
assign pkt_rd_head = heads[pkt_rd_idx];

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        running      <= 1'b0;
        mid_valid    <= 1'b0;
        pkt_full_cnt <= '0;
        for (int q = 0; q < NB_PKT_QUEUES; q++) begin
            tails[q] <= '0;
            heads[q] <= '0;
        end
    end else begin
        running <= 1'b1;
        if (!mid_valid || mid_ready) begin
            mid_valid <= in_fire && fits;
        end
        if (in_fire) begin
            if (fits) begin
                tails[in_pkt_qid] <= rb_advance(cur_tail, rb_size_t'(in_size), pkt_rb_size);
            end else begin
                pkt_full_cnt <= pkt_full_cnt + 1'b1;
            end
        end
        if (pkt_head_wr) begin
            heads[pkt_head_idx] <= pkt_head_data;
        end
    end
end

// The packet lands at the old tail of its flow.
always_ff @(posedge pcie_clk) begin
    if (in_fire && fits) begin
        mid_pkt_qid <= in_pkt_qid;
        mid_pkt_ptr <= cur_tail;
        mid_dsc_qid <= in_dsc_qid;
        mid_size    <= in_size;
    end
end

a_in_size_nonzero: assert property (
    @(posedge pcie_clk) disable iff (!pcie_reset_n)
    in_valid |-> (in_size != '0)
) else $error("Metadata item with a size of zero flits");

a_mid_stable: assert property (
    @(posedge pcie_clk) disable iff (!pcie_reset_n)
    (mid_valid && !mid_ready) |=>
        (mid_valid && $stable({mid_pkt_qid, mid_pkt_ptr, mid_dsc_qid, mid_size}))
) else $error("Stage one changed its item while stalled");

endmodule

`default_nettype wire

/* pcie_rx_queues.f */
+incdir+include
hdl/pcie_rx_pkg.sv
hdl/mmio_regs.sv
hdl/pkt_queue_manager.sv
hdl/dsc_queue_manager.sv
hdl/pcie_rx_top.sv
test/tb_pcie_rx.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and decides on the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f pcie_rx_queues.f \
    --top-module tb_pcie_rx \
    -o tb_pcie_rx > sim.log 2>&1 &&
    ./obj_dir/tb_pcie_rx >> sim.log 2>&1
grep -q '^>>> PASS$' sim.log && echo "Simulation passed" || {
    echo "Simulation failed, see sim.log"
    exit 1
}

/* include/tb_rx_model.svh */
`ifndef TB_RX_MODEL_SVH
`define TB_RX_MODEL_SVH

// A descriptor as the block is expected to emit it.
typedef struct packed {
    pkt_qid_t  pkt_qid;
    rb_ptr_t   pkt_ptr;
    dsc_qid_t  dsc_qid;
    rb_ptr_t   dsc_ptr;
    flit_cnt_t size;
} desc_t;

int    m_pkt_size = 256;
int    m_dsc_size = 16;
int    m_pkt_tail [NB_PKT_QUEUES];
int    m_pkt_head [NB_PKT_QUEUES];
int    m_dsc_tail [NB_DSC_QUEUES];
int    m_dsc_head [NB_DSC_QUEUES];
int    m_pkt_drops;
int    m_dsc_drops;
int    m_head_writes;
int    m_wraps;
int    m_expected;
desc_t exp_q [$];

function automatic int ring_space(int head, int tail, int size);
    int space;
    space = (head - tail - 1) % size;
    if (space < 0) begin
        space = space + size;
    end
    return space;
endfunction

// Applies the ring rule of both stages, in order, to one accepted item.
function automatic void predict_item(int pq, int dq, int sz);
    desc_t d;
    if (sz > ring_space(m_pkt_head[pq], m_pkt_tail[pq], m_pkt_size)) begin
        m_pkt_drops++;
    end else begin
        d.pkt_qid = pkt_qid_t'(pq);
        d.pkt_ptr = rb_ptr_t'(m_pkt_tail[pq]);
        d.dsc_qid = dsc_qid_t'(dq);
        d.size    = flit_cnt_t'(sz);
        if (m_pkt_tail[pq] + sz >= m_pkt_size) begin
            m_wraps++;
        end
        m_pkt_tail[pq] = (m_pkt_tail[pq] + sz) % m_pkt_size;
        // The packet ring space stays claimed when the descriptor ring is full.
        if (ring_space(m_dsc_head[dq], m_dsc_tail[dq], m_dsc_size) < 1) begin
            m_dsc_drops++;
        end else begin
            d.dsc_ptr      = rb_ptr_t'(m_dsc_tail[dq]);
            m_dsc_tail[dq] = (m_dsc_tail[dq] + 1) % m_dsc_size;
            exp_q.push_back(d);
            m_expected++;
        end
    end
endfunction

`endif

/* test/tb_pcie_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_rx;

import pcie_rx_pkg::*;

`include "tb_rx_model.svh"

localparam int BATCH_ITEMS = 20;
localparam int RAND_ITEMS  = 200;
localparam int READY_ITEMS = 100;
// The flow fill, descriptor fill and disable tests add 18, 19 and 6 items.
localparam int TOTAL_ITEMS     = RAND_ITEMS + READY_ITEMS + 18 + 19 + 6;
localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * 20 + 2000;
localparam int DRAIN_CYCLES    = 100;

logic       pcie_clk;
logic       pcie_reset_n;
pkt_qid_t   in_pkt_qid;
dsc_qid_t   in_dsc_qid;
flit_cnt_t  in_size;
logic       in_valid;
logic       in_ready;
pkt_qid_t   out_pkt_qid;
rb_ptr_t    out_pkt_ptr;
dsc_qid_t   out_dsc_qid;
rb_ptr_t    out_dsc_ptr;
flit_cnt_t  out_size;
logic       out_valid;
logic       out_ready;
mmio_addr_t mmio_address;
logic       mmio_write;
reg_t       mmio_writedata;
logic       mmio_read;
reg_t       mmio_readdata;
logic       mmio_readdata_valid;

string      test_name;
int         out_count = 0;
logic       random_ready;
int         mark_drops;
int         mark_out;
int         mark_exp;

pcie_rx_top i_dut (
    .pcie_clk            (pcie_clk),
    .pcie_reset_n        (pcie_reset_n),
    .in_pkt_qid          (in_pkt_qid),
    .in_dsc_qid          (in_dsc_qid),
    .in_size             (in_size),
    .in_valid            (in_valid),
    .in_ready            (in_ready),
    .out_pkt_qid         (out_pkt_qid),
    .out_pkt_ptr         (out_pkt_ptr),
    .out_dsc_qid         (out_dsc_qid),
    .out_dsc_ptr         (out_dsc_ptr),
    .out_size            (out_size),
    .out_valid           (out_valid),
    .out_ready           (out_ready),
    .mmio_address        (mmio_address),
    .mmio_write          (mmio_write),
    .mmio_writedata      (mmio_writedata),
    .mmio_read           (mmio_read),
    .mmio_readdata       (mmio_readdata),
    .mmio_readdata_valid (mmio_readdata_valid)
);

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on the first error");
endtask

task automatic check(input string what, input longint expected, input longint actual);
    if (expected != actual) begin
        fail_run($sformatf("Error: test %s, %s: expected 0x%0h, actual 0x%0h",
                           test_name, what, expected, actual));
    end
endtask

task automatic mmio_wr(input mmio_addr_t addr, input int data);
    mmio_address   = addr;
    mmio_writedata = reg_t'(data);
    mmio_write     = 1'b1;
    @(posedge pcie_clk);
    #1;
    mmio_write = 1'b0;
endtask

// Read data is due exactly one cycle after the request.
task automatic expect_reg(input string what, input mmio_addr_t addr, input int expected);
    mmio_address = addr;
    mmio_read    = 1'b1;
    @(posedge pcie_clk);
    #1;
    mmio_read = 1'b0;
    if (!mmio_readdata_valid) begin
        fail_run($sformatf("Test %s: no readdata_valid one cycle after a read of %s",
                           test_name, what));
    end
    check(what, expected, mmio_readdata);
endtask

task automatic write_dsc_head(input int q, input int value);
    mmio_wr(DSC_Q_BASE + mmio_addr_t'(2 * q + 1), value);
    m_dsc_head[q] = value;
    m_head_writes++;
endtask

// Setting every head to its tail leaves each ring with size minus one free.
task automatic refresh_heads();
    for (int q = 0; q < NB_PKT_QUEUES; q++) begin
        mmio_wr(PKT_Q_BASE + mmio_addr_t'(2 * q + 1), m_pkt_tail[q]);
        m_pkt_head[q] = m_pkt_tail[q];
        m_head_writes++;
    end
    for (int q = 0; q < NB_DSC_QUEUES; q++) begin
        write_dsc_head(q, m_dsc_tail[q]);
    end
endtask

task automatic check_tables();
    for (int q = 0; q < NB_PKT_QUEUES; q++) begin
        expect_reg($sformatf("pkt tail %0d", q), PKT_Q_BASE + mmio_addr_t'(2 * q),
                   m_pkt_tail[q]);
        expect_reg($sformatf("pkt head %0d", q), PKT_Q_BASE + mmio_addr_t'(2 * q + 1),
                   m_pkt_head[q]);
    end
    for (int q = 0; q < NB_DSC_QUEUES; q++) begin
        expect_reg($sformatf("dsc tail %0d", q), DSC_Q_BASE + mmio_addr_t'(2 * q),
                   m_dsc_tail[q]);
        expect_reg($sformatf("dsc head %0d", q), DSC_Q_BASE + mmio_addr_t'(2 * q + 1),
                   m_dsc_head[q]);
    end
endtask

task automatic send_item(input int pq, input int dq, input int sz);
    in_pkt_qid = pkt_qid_t'(pq);
    in_dsc_qid = dsc_qid_t'(dq);
    in_size    = flit_cnt_t'(sz);
    in_valid   = 1'b1;
    @(posedge pcie_clk);
    while (!in_ready) begin
        @(posedge pcie_clk);
    end
    predict_item(pq, dq, sz);
    #1;
    in_valid = 1'b0;
endtask

// Items still in flight after the last expected descriptor can only be drops.
task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < DRAIN_CYCLES) begin
        @(posedge pcie_clk);
        cycles++;
    end
    repeat (4) @(posedge pcie_clk);
    #1;
endtask

task automatic send_random(input int n);
    int pq;
    int dq;
    int sz;
    for (int i = 0; i < n; i++) begin
        if (i % BATCH_ITEMS == 0) begin
            wait_drain();
            refresh_heads();
        end
        pq = $urandom_range(0, NB_PKT_QUEUES - 1);
        dq = $urandom_range(0, NB_DSC_QUEUES - 1);
        sz = $urandom_range(1, 8);
        send_item(pq, dq, sz);
    end
endtask

initial begin
    pcie_clk = 1'b0;
    forever #4 pcie_clk = ~pcie_clk;
end

initial begin
    out_ready = 1'b1;
    forever begin
        @(posedge pcie_clk);
        #1;
        out_ready = random_ready ? ($urandom_range(0, 99) < 40) : 1'b1;
    end
end

always @(posedge pcie_clk) begin
    desc_t exp_d;
    if (pcie_reset_n && out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
            fail_run($sformatf("Test %s: a descriptor left the block when none was expected",
                               test_name));
        end else begin
            exp_d = exp_q.pop_front();
            check("out_pkt_qid", exp_d.pkt_qid, out_pkt_qid);
            check("out_pkt_ptr", exp_d.pkt_ptr, out_pkt_ptr);
            check("out_dsc_qid", exp_d.dsc_qid, out_dsc_qid);
            check("out_dsc_ptr", exp_d.dsc_ptr, out_dsc_ptr);
            check("out_size", exp_d.size, out_size);
            out_count++;
        end
    end
end

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge pcie_clk);
    fail_run("Watchdog expired: the simulation hung before all tests finished");
end

initial begin
    void'($urandom(53));
    pcie_reset_n   = 1'b0;
    in_pkt_qid     = '0;
    in_dsc_qid     = '0;
    in_size        = '0;
    in_valid       = 1'b0;
    mmio_address   = '0;
    mmio_write     = 1'b0;
    mmio_writedata = '0;
    mmio_read      = 1'b0;
    random_ready   = 1'b0;
    test_name      = "reset";
    repeat (10) @(posedge pcie_clk);
    check("in_ready in reset", 0, in_ready);
    check("out_valid in reset", 0, out_valid);
    check("readdata_valid in reset", 0, mmio_readdata_valid);
    #1;
    pcie_reset_n = 1'b1;
    @(posedge pcie_clk);
    #1;

    test_name = "reset values";
    expect_reg("ctrl", REG_CTRL, 0);
    expect_reg("pkt ring size", REG_PKT_RB_SIZE, 256);
    expect_reg("dsc ring size", REG_DSC_RB_SIZE, 16);
    expect_reg("pkt full count", REG_PKT_FULL_CNT, 0);
    expect_reg("dsc full count", REG_DSC_FULL_CNT, 0);
    expect_reg("head update count", REG_HEAD_UPD_CNT, 0);
    expect_reg("unmapped word", mmio_addr_t'(100), 0);
    check_tables();
    // Sizes that are not powers of two exercise the modulo wrap.
    mmio_wr(REG_PKT_RB_SIZE, 100);
    mmio_wr(REG_DSC_RB_SIZE, 12);
    m_pkt_size = 100;
    m_dsc_size = 12;
    expect_reg("pkt ring size", REG_PKT_RB_SIZE, 100);
    expect_reg("dsc ring size", REG_DSC_RB_SIZE, 12);

    test_name = "random stream";
    send_random(RAND_ITEMS);
    wait_drain();
    check("pkt tail wrapped", 1, m_wraps > 0);
    check_tables();

    test_name = "flow fill";
    refresh_heads();
    mark_drops = m_pkt_drops;
    for (int i = 0; i < 15; i++) begin
        send_item(5, i % 4, 8);
    end
    send_item(5, 3, 3);
    send_item(5, 0, 1);
    send_item(2, 1, 8);
    wait_drain();
    // 99 free flits hold twelve 8-flit packets and then one 3-flit packet.
    check("flow 5 drops", 4, m_pkt_drops - mark_drops);
    expect_reg("pkt full count", REG_PKT_FULL_CNT, m_pkt_drops);
    check_tables();

    test_name = "descriptor fill";
    refresh_heads();
    mark_drops = m_dsc_drops;
    for (int i = 0; i < 14; i++) begin
        send_item(i % 8, 2, 1);
    end
    wait_drain();
    check("dsc queue 2 drops", 3, m_dsc_drops - mark_drops);
    expect_reg("dsc full count", REG_DSC_FULL_CNT, m_dsc_drops);
    write_dsc_head(2, (m_dsc_head[2] + 4) % m_dsc_size);
    for (int i = 0; i < 5; i++) begin
        send_item(i, 2, 1);
    end
    wait_drain();
    check("dsc queue 2 drops", 4, m_dsc_drops - mark_drops);
    expect_reg("dsc full count", REG_DSC_FULL_CNT, m_dsc_drops);
    expect_reg("head update count", REG_HEAD_UPD_CNT, m_head_writes);
    check_tables();

    test_name    = "random ready";
    mark_out     = out_count;
    mark_exp     = m_expected;
    random_ready = 1'b1;
    send_random(READY_ITEMS);
    wait_drain();
    random_ready = 1'b0;
    check("descriptors delivered", m_expected - mark_exp, out_count - mark_out);

    test_name = "disable";
    mmio_wr(REG_CTRL, 1);
    expect_reg("ctrl", REG_CTRL, 1);
    in_pkt_qid = pkt_qid_t'(3);
    in_dsc_qid = dsc_qid_t'(1);
    in_size    = flit_cnt_t'(4);
    in_valid   = 1'b1;
    repeat (50) begin
        @(posedge pcie_clk);
        check("in_ready while disabled", 0, in_ready);
        check("out_valid while disabled", 0, out_valid);
    end
    #1;
    mmio_wr(REG_CTRL, 0);
    send_item(3, 1, 4);
    for (int i = 0; i < 5; i++) begin
        send_item(i + 1, i % 4, i + 2);
    end
    wait_drain();
    expect_reg("pkt full count", REG_PKT_FULL_CNT, m_pkt_drops);
    expect_reg("dsc full count", REG_DSC_FULL_CNT, m_dsc_drops);
    check_tables();

    if (exp_q.size() == 0 && out_count == m_expected) begin
        $display(">>> PASS");
        $finish;
    end else begin
        fail_run("Predicted descriptors never left the block by the end of the run");
    end
end

endmodule

`default_nettype wire
